// File: Makefile
TOP = master_sync_tb

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "No errors"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module master_sync_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: bench/master_sync_tb.sv
`timescale 1ns/1ps

module master_sync_tb;

	localparam int NODES = 4;
	localparam int BUSY_LIMIT = 6 * NODES + 6;

	logic clk;
	logic reset;
	logic [msync_pkg::RX_ADDR_W-1:0] rx_addr;
	logic [msync_pkg::BYTE_W-1:0] rx_data;
	logic rx_we;
	logic snap_tx;
	logic snap_rx;
	logic psel;
	logic penable;
	logic pwrite;
	logic [msync_pkg::APB_ADDR_W-1:0] paddr;
	logic [msync_pkg::APB_DATA_W-1:0] pwdata;
	logic [msync_pkg::APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;

	// Reference model state.
	msync_pkg::stamp_t stamps [NODES][msync_pkg::STAMPS];
	msync_pkg::stamp_t model_cnt;
	msync_pkg::stamp_t exp_tx;
	msync_pkg::stamp_t exp_rx;
	msync_pkg::stamp_t frozen_tx;
	msync_pkg::stamp_t frozen_rx;
	int cycles;
	int errors;
	int checks;
	int tests;
	int failed_tests;
	int test_start_errors;
	bit timed_out;

	tb_clock u_clock (
		.clk_o(clk),
		.reset_o(reset)
	);

	master_sync_top #(
		.NODES(NODES)
	) u_dut (
		.clk_i(clk),
		.reset_i(reset),
		.rx_addr_i(rx_addr),
		.rx_data_i(rx_data),
		.rx_we_i(rx_we),
		.snap_tx_i(snap_tx),
		.snap_rx_i(snap_rx),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr)
	);

	// ------------------------------
	// Local counter and snapshot model.
	always @(posedge clk) begin
		if (reset) begin
			model_cnt = '0;
			exp_tx = '0;
			exp_rx = '0;
			cycles = 0;
		end else begin
			if (snap_tx)
				exp_tx = model_cnt; // Value before this edge's increment.
			if (snap_rx)
				exp_rx = model_cnt;
			model_cnt = {1'b0, model_cnt[14:0] + 15'd1};
			cycles++;
		end
	end

	// ------------------------------
	// Compare tasks.
	task automatic check_mask(input string what, input logic [NODES-1:0] got,
		input logic [NODES-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_result(input string what, input msync_pkg::result_t got,
		input msync_pkg::result_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected delay %h offset %h got delay %h offset %h",
				$time, what, exp.delay, exp.offset, got.delay, got.offset);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_start_errors) begin
			failed_tests++;
			$display("test %0d %s: failed", tests, name);
		end else begin
			$display("test %0d %s: passed", tests, name);
		end
		test_start_errors = errors;
	endtask

	// ------------------------------
	// Bus drivers.
	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#5;
		rdata = prdata; // Mid access phase.
		err = pslverr;
		check_bit("pready", pready, 1'b1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic rx_write(input int node, input int byte_idx, input logic [7:0] data);
		int slot;
		@(negedge clk);
		rx_addr = msync_pkg::RX_BASE + 10'(node * msync_pkg::MSG_LEN + byte_idx);
		rx_data = data;
		rx_we = 1'b1;
		@(negedge clk);
		rx_we = 1'b0;
		if (byte_idx >= 4 && byte_idx < 12) begin
			slot = (byte_idx - 4) / 2;
			if (byte_idx % 2 == 1)
				stamps[node][slot][15:8] = data;
			else
				stamps[node][slot][7:0] = data;
		end
	endtask

	task automatic snap_pulse(input bit is_tx, input int idle);
		repeat (idle) @(negedge clk);
		@(negedge clk);
		if (is_tx)
			snap_tx = 1'b1;
		else
			snap_rx = 1'b1;
		@(negedge clk);
		snap_tx = 1'b0;
		snap_rx = 1'b0;
	endtask

	// Delay and offset from the four terms with the half-wrap fix.
	function automatic msync_pkg::result_t predict(input int n);
		msync_pkg::stamp_t a;
		msync_pkg::stamp_t b;
		msync_pkg::stamp_t c;
		msync_pkg::stamp_t d;
		msync_pkg::result_t r;
		logic [3:0] pat;
		a = stamps[n][0];
		b = stamps[n][1];
		if (n == 0) begin
			c = frozen_tx;
			d = frozen_rx;
		end else begin
			c = stamps[n-1][2];
			d = stamps[n-1][3];
		end
		r.delay = a - b - c + d;
		r.offset = a + b - c - d;
		pat = {d[14], c[14], b[14], a[14]};
		if (pat == 4'b0100 || pat == 4'b0010 || pat == 4'b0111)
			r.offset = r.offset + 16'h8000;
		return r;
	endfunction

	task automatic read_results(input bit expect_zero);
		logic [31:0] off_word;
		logic [31:0] dly_word;
		logic off_err;
		logic dly_err;
		msync_pkg::result_t got;
		msync_pkg::result_t exp;
		for (int n = 0; n < NODES; n++) begin
			apb_access(1'b0, msync_pkg::REG_OFFSET_BASE + 8'(4 * n), '0, off_word, off_err);
			apb_access(1'b0, msync_pkg::REG_DELAY_BASE + 8'(4 * n), '0, dly_word, dly_err);
			check_bit($sformatf("node %0d read pslverr", n), off_err | dly_err, 1'b0);
			got.offset = off_word[15:0];
			got.delay = dly_word[15:0];
			exp = expect_zero ? '0 : predict(n);
			check_result($sformatf("node %0d result", n), got, exp);
		end
	endtask

	task automatic read_masks(input logic [NODES-1:0] rx_ok, input logic [NODES-1:0] sync_ok,
		input logic [NODES-1:0] slave_rdy, input logic [NODES-1:0] scope_req);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, msync_pkg::REG_RX_OK, '0, rd, err);
		check_bit("rx_ok read pslverr", err, 1'b0);
		check_mask("rx_ok", rd[NODES-1:0], rx_ok);
		apb_access(1'b0, msync_pkg::REG_SYNC_OK, '0, rd, err);
		check_bit("sync_ok read pslverr", err, 1'b0);
		check_mask("sync_ok", rd[NODES-1:0], sync_ok);
		apb_access(1'b0, msync_pkg::REG_SLAVE_RDY, '0, rd, err);
		check_bit("slave_rdy read pslverr", err, 1'b0);
		check_mask("slave_rdy", rd[NODES-1:0], slave_rdy);
		apb_access(1'b0, msync_pkg::REG_SCOPE_REQ, '0, rd, err);
		check_bit("scope_req read pslverr", err, 1'b0);
		check_mask("scope_req", rd[NODES-1:0], scope_req);
	endtask

	// ------------------------------
	// Cycle start with a second start while busy.
	task automatic run_cycle();
		logic [31:0] rd;
		logic err;
		int start;
		int polls;
		frozen_tx = exp_tx;
		frozen_rx = exp_rx;
		apb_access(1'b1, msync_pkg::REG_CTRL, 32'd1, rd, err);
		check_bit("ctrl write pslverr", err, 1'b0);
		start = cycles;
		rd = '0;
		polls = 0;
		while (!rd[0] && polls < 4) begin
			apb_access(1'b0, msync_pkg::REG_STATUS, '0, rd, err);
			polls++;
		end
		check_bit("busy after start", rd[0], 1'b1);
		apb_access(1'b1, msync_pkg::REG_CTRL, 32'd1, rd, err); // Must be ignored.
		rd = 32'd1;
		polls = 0;
		while (rd[0] && polls < 4 * BUSY_LIMIT) begin
			apb_access(1'b0, msync_pkg::REG_STATUS, '0, rd, err);
			polls++;
		end
		if (rd[0]) begin
			$display("Timeout: busy never cleared after a cycle start");
			errors++;
			timed_out = 1'b1;
		end else begin
			checks++;
			if (cycles - start > BUSY_LIMIT) begin
				errors++;
				$display("Fail at %0t: busy lasted %0d cycles, limit %0d", $time,
					cycles - start, BUSY_LIMIT);
			end
			read_results(1'b0);
		end
	endtask

	task automatic check_reset_values();
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, msync_pkg::REG_CTRL, '0, rd, err);
		check_bit("ctrl read pslverr", err, 1'b0);
		check_bit("ctrl reads 0", |rd, 1'b0);
		apb_access(1'b0, msync_pkg::REG_STATUS, '0, rd, err);
		check_bit("status read pslverr", err, 1'b0);
		check_bit("status reads 0", |rd, 1'b0);
		read_masks('0, '0, '0, '0);
		read_results(1'b1);
		apb_access(1'b0, 8'h30, '0, rd, err);
		check_bit("unmapped read pslverr", err, 1'b1);
		apb_access(1'b1, msync_pkg::REG_STATUS, 32'd1, rd, err);
		check_bit("status write pslverr", err, 1'b1);
	endtask

	// ------------------------------
	// Trace player.
	initial begin
		int fd;
		int waited;
		int f0;
		int f1;
		int f2;
		int f3;
		byte op;
		string line;
		logic [31:0] rd;
		logic err;

		rx_addr = '0;
		rx_data = '0;
		rx_we = 1'b0;
		snap_tx = 1'b0;
		snap_rx = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		test_start_errors = 0;
		timed_out = 1'b0;
		frozen_tx = '0;
		frozen_rx = '0;
		for (int n = 0; n < NODES; n++) begin
			for (int s = 0; s < msync_pkg::STAMPS; s++) begin
				stamps[n][s] = '0;
			end
		end
		void'($urandom(32'h2df0));

		waited = 0;
		while (reset !== 1'b0 && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (reset !== 1'b0) begin
			$display("Timeout: reset was never released");
			errors++;
			timed_out = 1'b1;
		end else begin
			check_reset_values();
			end_test("reset values");
		end

		fd = $fopen("bench/master_sync_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			errors++;
		end
		while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
			op = line.getc(0);
			f0 = 0;
			f1 = 0;
			f2 = 0;
			f3 = 0;
			if (line.len() > 1)
				void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3));
			case (op)
				"W": rx_write(f0, f1, 8'(f2));
				"F": begin // Random stamps for every node in order.
					for (int n = 0; n < NODES; n++) begin
						for (int b = 4; b < 12; b++) begin
							rx_write(n, b, 8'($urandom));
						end
					end
				end
				"T": snap_pulse(1'b1, f0);
				"R": snap_pulse(1'b0, f0);
				"C": begin
					run_cycle();
					end_test("cycle results");
				end
				"M": begin
					read_masks(NODES'(f0), NODES'(f1), NODES'(f2), NODES'(f3));
					end_test("status masks");
				end
				"X": begin
					apb_access(f1[0], 8'(f0), 32'd1, rd, err);
					check_bit($sformatf("pslverr at %h", f0), err, 1'b1);
					end_test("bus error");
				end
				default: ;
			endcase
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#1000000;
		$display("Watchdog expired before the trace finished");
		$display("Errors found");
		$finish;
	end

endmodule

// File: bench/master_sync_trace.txt
# W node byte data | F random stamps | T/R idle_cycles | C start cycle
# M rx_ok sync_ok slave_rdy scope_req | X addr write (expects pslverr), all hex
F
W 0 2 07
W 1 2 01
W 2 2 03
W 3 2 04
T 3
R 5
C
M f 7 5 9
W 0 4 11
W 0 5 22
W 1 4 33
W 1 5 44
W 3 4 55
W 3 5 66
W 0 2 01
W 3 2 01
C
M 3 1 0 0
C
M 0 0 0 0
W 0 8 00
W 0 9 40
W 0 a 00
W 0 b 01
W 1 4 00
W 1 5 10
W 1 6 00
W 1 7 08
T 2
R 4
C
M 3 0 0 0
X 30 0
X 04 1
X 90 0
X 42 0
X 14 1

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 10
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// Reset held for two rising edges, released on a falling edge.
	initial begin
		reset_o = 1'b1;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// File: compile.f
design/msync_pkg.sv
design/rx_stamp_store.sv
design/offset_engine.sv
design/msync_apb_regs.sv
design/master_sync_top.sv
bench/tb_clock.sv
bench/master_sync_tb.sv

// File: design/master_sync_top.sv
`timescale 1ns/1ps

module master_sync_top #(
	parameter int NODES = 4
) (
	input  logic                                 clk_i,
	input  logic                                 reset_i,
	input  logic [msync_pkg::RX_ADDR_W-1:0]      rx_addr_i,
	input  logic [msync_pkg::BYTE_W-1:0]         rx_data_i,
	input  logic                                 rx_we_i,
	input  logic                                 snap_tx_i,
	input  logic                                 snap_rx_i,
	input  logic                                 psel_i,
	input  logic                                 penable_i,
	input  logic                                 pwrite_i,
	input  logic [msync_pkg::APB_ADDR_W-1:0]     paddr_i,
	input  logic [msync_pkg::APB_DATA_W-1:0]     pwdata_i,
	output logic [msync_pkg::APB_DATA_W-1:0]     prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o
);

	localparam int NODE_W = $clog2(NODES);

	logic cycle_start;
	logic busy;
	logic [NODE_W-1:0] rd_node;
	logic [msync_pkg::SLOT_W-1:0] rd_slot;
	msync_pkg::stamp_t rd_stamp;
	msync_pkg::stamp_t snap_tx;
	msync_pkg::stamp_t snap_rx;
	logic [NODES-1:0] rx_ok;
	logic [NODES-1:0] sync_ok;
	logic [NODES-1:0] slave_rdy;
	logic [NODES-1:0] scope_req;
	msync_pkg::result_t [NODES-1:0] results;

	rx_stamp_store #(
		.NODES(NODES)
	) u_store (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.rx_addr_i(rx_addr_i),
		.rx_data_i(rx_data_i),
		.rx_we_i(rx_we_i),
		.snap_tx_i(snap_tx_i),
		.snap_rx_i(snap_rx_i),
		.cycle_start_i(cycle_start),
		.rd_node_i(rd_node),
		.rd_slot_i(rd_slot),
		.rd_stamp_o(rd_stamp),
		.snap_tx_o(snap_tx),
		.snap_rx_o(snap_rx),
		.rx_ok_o(rx_ok),
		.sync_ok_o(sync_ok),
		.slave_rdy_o(slave_rdy),
		.scope_req_o(scope_req)
	);

	offset_engine #(
		.NODES(NODES)
	) u_engine (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.cycle_start_i(cycle_start),
		.rd_stamp_i(rd_stamp),
		.snap_tx_i(snap_tx),
		.snap_rx_i(snap_rx),
		.rd_node_o(rd_node),
		.rd_slot_o(rd_slot),
		.busy_o(busy),
		.results_o(results)
	);

	msync_apb_regs #(
		.NODES(NODES)
	) u_regs (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.busy_i(busy),
		.rx_ok_i(rx_ok),
		.sync_ok_i(sync_ok),
		.slave_rdy_i(slave_rdy),
		.scope_req_i(scope_req),
		.results_i(results),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.cycle_start_o(cycle_start)
	);

endmodule

// File: design/msync_apb_regs.sv
`timescale 1ns/1ps

module msync_apb_regs #(
	parameter int NODES = 4
) (
	input  logic                                 clk_i,
	input  logic                                 reset_i,
	input  logic                                 psel_i,
	input  logic                                 penable_i,
	input  logic                                 pwrite_i,
	input  logic [msync_pkg::APB_ADDR_W-1:0]     paddr_i,
	input  logic [msync_pkg::APB_DATA_W-1:0]     pwdata_i,
	input  logic                                 busy_i,
	input  logic [NODES-1:0]                     rx_ok_i,
	input  logic [NODES-1:0]                     sync_ok_i,
	input  logic [NODES-1:0]                     slave_rdy_i,
	input  logic [NODES-1:0]                     scope_req_i,
	input  msync_pkg::result_t [NODES-1:0]       results_i,
	output logic [msync_pkg::APB_DATA_W-1:0]     prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o,
	output logic                                 cycle_start_o
);

	localparam int NODE_W = $clog2(NODES);
	localparam int WIN_SIZE = 4 * NODES;
	localparam int S_W = msync_pkg::STAMP_W;

	logic access;
	logic mapped;
	logic off_hit;
	logic dly_hit;
	logic [msync_pkg::APB_ADDR_W-1:0] off_rel;
	logic [msync_pkg::APB_ADDR_W-1:0] dly_rel;

	assign access = psel_i & penable_i;
	assign pready_o = 1'b1; // No wait states.

	// ------------------------------
	// Read decode.
	always_comb begin
		off_rel = paddr_i - msync_pkg::REG_OFFSET_BASE;
		dly_rel = paddr_i - msync_pkg::REG_DELAY_BASE;
		off_hit = (int'(off_rel) < WIN_SIZE) && (paddr_i[1:0] == 2'b00);
		dly_hit = (int'(dly_rel) < WIN_SIZE) && (paddr_i[1:0] == 2'b00);
		prdata_o = '0;
		mapped = 1'b1;
		case (paddr_i)
			msync_pkg::REG_CTRL: prdata_o = '0; // Start bit reads back as 0.
			msync_pkg::REG_STATUS: prdata_o[0] = busy_i;
			msync_pkg::REG_RX_OK: prdata_o[NODES-1:0] = rx_ok_i;
			msync_pkg::REG_SYNC_OK: prdata_o[NODES-1:0] = sync_ok_i;
			msync_pkg::REG_SLAVE_RDY: prdata_o[NODES-1:0] = slave_rdy_i;
			msync_pkg::REG_SCOPE_REQ: prdata_o[NODES-1:0] = scope_req_i;
			default: begin
				if (off_hit)
					prdata_o[S_W-1:0] = results_i[off_rel[2 +: NODE_W]].offset;
				else if (dly_hit)
					prdata_o[S_W-1:0] = results_i[dly_rel[2 +: NODE_W]].delay;
				else
					mapped = 1'b0;
			end
		endcase
	end

	// Only the control word is writable.
	assign pslverr_o = access & (~mapped | (pwrite_i & (paddr_i != msync_pkg::REG_CTRL)));

	// ------------------------------
	// Cycle start pulse.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cycle_start_o <= 1'b0;
		end else begin
			cycle_start_o <= access & pwrite_i & (paddr_i == msync_pkg::REG_CTRL) &
				pwdata_i[0] & ~busy_i; // Dropped while the engine runs.
		end
	end

endmodule

// File: design/msync_pkg.sv
package msync_pkg;

	// Data widths.
	localparam int STAMP_W = 16;
	localparam int BYTE_W = 8;
	localparam int RX_ADDR_W = 10;
	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	// ------------------------------
	// Receive buffer layout.
	localparam logic [RX_ADDR_W-1:0] RX_BASE = 10'd64; // Start of high-priority area.
	localparam int MSG_LEN = 16; // Bytes per node message.
	localparam int FLAG_BYTE = 2; // Flag word with the low byte first.
	localparam int STAMP_BYTE = 4; // Timestamp 0 low byte.
	localparam int STAMPS = 4;
	localparam int SLOT_W = $clog2(STAMPS);

	// ------------------------------
	// APB register map.
	localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_RX_OK = 8'h08;
	localparam logic [APB_ADDR_W-1:0] REG_SYNC_OK = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] REG_SLAVE_RDY = 8'h10;
	localparam logic [APB_ADDR_W-1:0] REG_SCOPE_REQ = 8'h14;
	localparam logic [APB_ADDR_W-1:0] REG_OFFSET_BASE = 8'h40; // One word per node.
	localparam logic [APB_ADDR_W-1:0] REG_DELAY_BASE = 8'h80;

	// ------------------------------
	// Result types.
	typedef logic [STAMP_W-1:0] stamp_t;

	typedef struct packed {
		stamp_t delay;
		stamp_t offset;
	} result_t;

endpackage

// File: design/offset_engine.sv
`timescale 1ns/1ps

module offset_engine #(
	parameter int NODES = 4
) (
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic                              cycle_start_i,
	input  msync_pkg::stamp_t                 rd_stamp_i,
	input  msync_pkg::stamp_t                 snap_tx_i,
	input  msync_pkg::stamp_t                 snap_rx_i,
	output logic [$clog2(NODES)-1:0]          rd_node_o,
	output logic [msync_pkg::SLOT_W-1:0]      rd_slot_o,
	output logic                              busy_o,
	output msync_pkg::result_t [NODES-1:0]    results_o
);

	localparam int NODE_W = $clog2(NODES);
	localparam int SIGN_BIT = msync_pkg::STAMP_W - 2;
	localparam logic [NODE_W-1:0] LAST_NODE = NODE_W'(NODES - 1);
	localparam logic [msync_pkg::SLOT_W-1:0] SLOT_A = 0;
	localparam logic [msync_pkg::SLOT_W-1:0] SLOT_B = 1;
	localparam logic [msync_pkg::SLOT_W-1:0] SLOT_C = 2;
	localparam logic [msync_pkg::SLOT_W-1:0] SLOT_D = 3;
	localparam msync_pkg::stamp_t HALF_WRAP = 16'h8000;

	typedef enum logic [2:0] {
		S_IDLE,
		S_TERM_A,
		S_TERM_B,
		S_TERM_C,
		S_TERM_D,
		S_CORR,
		S_STORE
	} state_t;

	state_t state;
	logic [NODE_W-1:0] node;
	logic [NODE_W-1:0] prev_node;
	msync_pkg::stamp_t term;
	msync_pkg::stamp_t acc_delay;
	msync_pkg::stamp_t acc_offset;
	logic [3:0] sign_hist;
	logic fix_offset;

	assign busy_o = (state != S_IDLE);
	assign prev_node = (node == '0) ? node : node - 1'b1;

	// ------------------------------
	// Term select.
	always_comb begin
		rd_node_o = node;
		rd_slot_o = SLOT_A;
		term = rd_stamp_i;
		case (state)
			S_TERM_B: rd_slot_o = SLOT_B;
			S_TERM_C: begin
				rd_node_o = prev_node;
				rd_slot_o = SLOT_C;
				if (node == '0)
					term = snap_tx_i; // Master's own tx stamp.
			end
			S_TERM_D: begin
				rd_node_o = prev_node;
				rd_slot_o = SLOT_D;
				if (node == '0)
					term = snap_rx_i;
			end
			default: rd_slot_o = SLOT_A;
		endcase
	end

	// Bit 14 history is {D, C, B, A} after the fourth term.
	assign fix_offset = (sign_hist == 4'b0100) || (sign_hist == 4'b0010) ||
		(sign_hist == 4'b0111);

	// ------------------------------
	// Sequencer.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_IDLE;
			node <= '0;
			results_o <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (cycle_start_i) begin
						state <= S_TERM_A;
						node <= '0;
					end
				end
				S_TERM_A: state <= S_TERM_B;
				S_TERM_B: state <= S_TERM_C;
				S_TERM_C: state <= S_TERM_D;
				S_TERM_D: state <= S_CORR;
				S_CORR: state <= S_STORE;
				S_STORE: begin
					results_o[node].delay <= acc_delay;
					results_o[node].offset <= acc_offset;
					if (node == LAST_NODE) begin
						state <= S_IDLE;
					end else begin
						node <= node + 1'b1;
						state <= S_TERM_A;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ------------------------------
	// ALU.
	always_ff @(posedge clk_i) begin
		case (state)
			S_TERM_A: begin
				acc_delay <= acc_delay + term;
				acc_offset <= acc_offset + term;
			end
			S_TERM_B: begin
				acc_delay <= acc_delay - term;
				acc_offset <= acc_offset + term;
			end
			S_TERM_C: begin
				acc_delay <= acc_delay - term;
				acc_offset <= acc_offset - term;
			end
			S_TERM_D: begin
				acc_delay <= acc_delay + term;
				acc_offset <= acc_offset - term;
			end
			S_CORR: begin
				if (fix_offset)
					acc_offset <= acc_offset + HALF_WRAP;
			end
			default: begin // Idle and store clear for the next node.
				acc_delay <= '0;
				acc_offset <= '0;
			end
		endcase

		if (state inside {S_TERM_A, S_TERM_B, S_TERM_C, S_TERM_D})
			sign_hist <= {term[SIGN_BIT], sign_hist[3:1]};
	end

endmodule

// File: design/rx_stamp_store.sv
`timescale 1ns/1ps

module rx_stamp_store #(
	parameter int NODES = 4
) (
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic [msync_pkg::RX_ADDR_W-1:0]   rx_addr_i,
	input  logic [msync_pkg::BYTE_W-1:0]      rx_data_i,
	input  logic                              rx_we_i,
	input  logic                              snap_tx_i,
	input  logic                              snap_rx_i,
	input  logic                              cycle_start_i,
	input  logic [$clog2(NODES)-1:0]          rd_node_i,
	input  logic [msync_pkg::SLOT_W-1:0]      rd_slot_i,
	output msync_pkg::stamp_t                 rd_stamp_o,
	output msync_pkg::stamp_t                 snap_tx_o,
	output msync_pkg::stamp_t                 snap_rx_o,
	output logic [NODES-1:0]                  rx_ok_o,
	output logic [NODES-1:0]                  sync_ok_o,
	output logic [NODES-1:0]                  slave_rdy_o,
	output logic [NODES-1:0]                  scope_req_o
);

	localparam int NODE_W = $clog2(NODES);
	localparam int SEL_W = $clog2(msync_pkg::MSG_LEN);
	localparam int AREA = NODES * msync_pkg::MSG_LEN;
	localparam int CNT_W = msync_pkg::STAMP_W - 1;
	localparam int B_W = msync_pkg::BYTE_W;
	localparam logic [SEL_W-1:0] FLAG_OFS = SEL_W'(msync_pkg::FLAG_BYTE);
	localparam logic [SEL_W-1:0] STAMP_OFS = SEL_W'(msync_pkg::STAMP_BYTE);
	localparam logic [SEL_W-1:0] STAMP_END = SEL_W'(msync_pkg::STAMP_BYTE + 2 * msync_pkg::STAMPS);

	logic [msync_pkg::RX_ADDR_W-1:0] rel_addr;
	logic [SEL_W-1:0] wr_byte;
	logic [SEL_W-1:0] stamp_rel;
	logic [NODE_W-1:0] wr_node;
	logic [msync_pkg::SLOT_W-1:0] wr_slot;
	logic in_area;
	logic wr_hi;
	logic flag_we;
	logic stamp_we;

	logic [NODES-1:0] rx_lo;
	logic [NODES-1:0] rx_hi;
	logic [NODES-1:0] received;
	logic [NODES-1:0] gate;

	msync_pkg::stamp_t stamp_mem [NODES*msync_pkg::STAMPS];
	msync_pkg::stamp_t flags [NODES];
	msync_pkg::stamp_t local_cnt;
	msync_pkg::stamp_t snap_tx_r;
	msync_pkg::stamp_t snap_rx_r;

	// ------------------------------
	// Receive address decode.
	always_comb begin
		rel_addr = rx_addr_i - msync_pkg::RX_BASE;
		in_area = (rx_addr_i >= msync_pkg::RX_BASE) && (int'(rel_addr) < AREA);
		wr_node = rel_addr[SEL_W +: NODE_W];
		wr_byte = rel_addr[SEL_W-1:0];
		stamp_rel = wr_byte - STAMP_OFS;
		wr_slot = stamp_rel[1 +: msync_pkg::SLOT_W];
		wr_hi = wr_byte[0]; // Odd byte is the high half.
		flag_we = rx_we_i && in_area && (wr_byte[SEL_W-1:1] == FLAG_OFS[SEL_W-1:1]);
		stamp_we = rx_we_i && in_area && (wr_byte >= STAMP_OFS) && (wr_byte < STAMP_END);
	end

	assign received = rx_lo & rx_hi;
	assign gate = {received[NODES-2:0], 1'b1}; // Node 0 is never gated.

	assign rd_stamp_o = stamp_mem[{rd_node_i, rd_slot_i}];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < NODES * msync_pkg::STAMPS; i++) begin
				stamp_mem[i] <= '0;
			end
		end else if (stamp_we) begin
			if (wr_hi)
				stamp_mem[{wr_node, wr_slot}][B_W +: B_W] <= rx_data_i;
			else
				stamp_mem[{wr_node, wr_slot}][0 +: B_W] <= rx_data_i;
		end
	end

	// ------------------------------
	// Reception, counter and status.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rx_lo <= '0;
			rx_hi <= '0;
			rx_ok_o <= '0;
			sync_ok_o <= '0;
			slave_rdy_o <= '0;
			scope_req_o <= '0;
			local_cnt <= '0;
			snap_tx_r <= '0;
			snap_rx_r <= '0;
			snap_tx_o <= '0;
			snap_rx_o <= '0;
			for (int n = 0; n < NODES; n++) begin
				flags[n] <= '0;
			end
		end else begin
			local_cnt <= {1'b0, local_cnt[CNT_W-1:0] + CNT_W'(1)}; // Wraps at 2^15.
			if (snap_tx_i)
				snap_tx_r <= local_cnt;
			if (snap_rx_i)
				snap_rx_r <= local_cnt;

			if (cycle_start_i) begin
				for (int n = 0; n < NODES; n++) begin
					rx_ok_o[n] <= received[n];
					sync_ok_o[n] <= received[n] & flags[n][0];
					slave_rdy_o[n] <= received[n] & flags[n][0] & flags[n][1];
					scope_req_o[n] <= received[n] & flags[n][2];
					flags[n] <= '0;
				end
				snap_tx_o <= snap_tx_r;
				snap_rx_o <= snap_rx_r;
				rx_lo <= '0;
				rx_hi <= '0;
			end else begin
				if (flag_we) begin
					if (wr_hi)
						flags[wr_node][B_W +: B_W] <= rx_data_i;
					else
						flags[wr_node][0 +: B_W] <= rx_data_i;
				end
				if (stamp_we && gate[wr_node]) begin
					if (!wr_hi)
						rx_lo[wr_node] <= 1'b1;
					else if (rx_lo[wr_node])
						rx_hi[wr_node] <= 1'b1; // High byte only after a low one.
				end
			end
		end
	end

endmodule
